//--- hdl/i2s_pkg.sv
package i2s_pkg;

    // one left-channel sample per frame
    localparam int SAMPLE_W = 16;

    typedef logic [SAMPLE_W-1:0] sample_t;

    // delay bit after the lrck fall plus the data bits
    localparam int SLOT_BITS = SAMPLE_W + 1;

    // must hold SLOT_BITS
    typedef logic [4:0] bit_cnt_t;

endpackage

//--- hdl/rec_pkg.sv
package rec_pkg;

    localparam int ADDR_W = 20;

    // word address into the sample memory
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_WAIT    = 2'd1,  // armed, next lrck fall starts capture
        ST_CAPTURE = 2'd2,
        ST_PAUSE   = 2'd3
    } rec_state_t;

    // wraps after 15
    typedef logic [3:0] second_t;

endpackage

//--- hdl/lane_sample_if.sv
interface lane_sample_if;
    import i2s_pkg::*;

    logic    valid;    // level, held until clear
    sample_t sample;
    logic    overrun;  // sticky, new sample landed on a held one
    logic    clear;    // one-cycle pulse from the writer

    modport lane (
        output valid,
        output sample,
        output overrun,
        input  clear
    );

    modport drain (
        input  valid,
        input  sample,
        output clear
    );

endinterface

//--- hdl/rec_sequencer.sv
module rec_sequencer #(
    parameter int FRAMES_PER_SEC = 48000
) (
    input  logic             i_bclk,
    input  logic             i_rst_n,
    input  logic             i_daclrck,
    input  logic             i_start,
    input  logic             i_pause,
    input  logic             i_stop,
    output logic             o_take,
    output logic             o_new_take_run,
    output rec_pkg::second_t o_second,
    output logic             o_recording
);
    import i2s_pkg::*;
    import rec_pkg::*;

    localparam int FCNT_W = $clog2(FRAMES_PER_SEC + 1);

    rec_state_t        state_r;
    rec_state_t        state_w;
    logic              lrck_q;
    logic              lrck_fall;
    logic              recording;
    logic              fresh_start;
    logic              last_frame;
    logic [FCNT_W-1:0] frame_cnt_r;
    second_t           second_r;
    logic              new_run_r;

    assign lrck_fall   = lrck_q & ~i_daclrck;
    assign recording   = (state_r == ST_CAPTURE) || (state_r == ST_WAIT);
    assign fresh_start = (state_r == ST_IDLE) && i_start && !i_stop;
    assign last_frame  = (frame_cnt_r == FCNT_W'(FRAMES_PER_SEC - 1));

    // a pause or stop in the fall cycle wins and that frame is not taken
    assign o_take = lrck_fall && recording && !i_stop && !i_pause;

    assign o_recording    = recording;
    assign o_second       = second_r;
    assign o_new_take_run = new_run_r;

    always_comb begin
        state_w = state_r;
        if (i_stop) begin
            state_w = ST_IDLE;
        end else begin
            case (state_r)
                ST_IDLE: begin
                    if (i_start) begin
                        state_w = ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (i_pause) begin
                        state_w = ST_PAUSE;
                    end else if (o_take) begin
                        state_w = ST_CAPTURE;
                    end
                end
                ST_CAPTURE: begin
                    if (i_pause) begin
                        state_w = ST_PAUSE;
                    end
                end
                ST_PAUSE: begin
                    if (i_start) begin
                        state_w = ST_WAIT;  // resume keeps address and seconds
                    end
                end
                default: state_w = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= ST_IDLE;
            lrck_q      <= 1'b0;  // no false fall out of reset
            new_run_r   <= 1'b0;
            frame_cnt_r <= '0;
            second_r    <= '0;
        end else begin
            state_r   <= state_w;
            lrck_q    <= i_daclrck;
            new_run_r <= fresh_start;
            if (fresh_start) begin
                frame_cnt_r <= '0;
                second_r    <= '0;
            end else if (o_take) begin
                if (last_frame) begin
                    frame_cnt_r <= '0;
                    second_r    <= second_r + 1'b1;
                end else begin
                    frame_cnt_r <= frame_cnt_r + 1'b1;
                end
            end
        end
    end

    // lanes need the whole slot before the next take
    a_take_spacing: assert property (
        @(posedge i_bclk) disable iff (!i_rst_n)
        o_take |=> (!o_take) [*SLOT_BITS - 1]
    );

endmodule

//--- hdl/i2s_rx_lane.sv
module i2s_rx_lane (
    input  logic i_bclk,
    input  logic i_rst_n,
    input  logic i_take,
    input  logic i_adcdat,
    lane_sample_if.lane s
);
    import i2s_pkg::*;

    bit_cnt_t            bit_cnt_r;  // 0 when not capturing
    logic [SAMPLE_W-2:0] shift_r;    // last data bit goes straight to sample
    logic                shifting;
    logic                done;

    assign shifting = (bit_cnt_r != '0);
    assign done     = (bit_cnt_r == bit_cnt_t'(SLOT_BITS - 1));

    // take cycle is the delay bit, so count it but don't shift
    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt_r <= '0;
        end else if (i_take) begin
            bit_cnt_r <= bit_cnt_t'(1);
        end else if (done) begin
            bit_cnt_r <= '0;
        end else if (shifting) begin
            bit_cnt_r <= bit_cnt_r + 1'b1;
        end
    end

    always_ff @(posedge i_bclk) begin
        if (shifting) begin
            shift_r <= {shift_r[SAMPLE_W-3:0], i_adcdat};  // msb first
        end
        if (done) begin
            s.sample <= {shift_r, i_adcdat};
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s.valid   <= 1'b0;
            s.overrun <= 1'b0;
        end else if (done) begin
            s.valid <= 1'b1;
            if (s.valid && !s.clear) begin
                s.overrun <= 1'b1;
            end
        end else if (s.clear) begin
            s.valid <= 1'b0;
        end
    end

    // the writer has to drain every sample before the next frame lands
    a_no_overrun: assert property (
        @(posedge i_bclk) disable iff (!i_rst_n)
        !s.overrun
    );

endmodule

//--- hdl/sample_writer.sv
module sample_writer #(
    parameter int NUM_LANES = 4
) (
    input  logic             i_bclk,
    input  logic             i_rst_n,
    input  logic             i_new_take_run,
    lane_sample_if.drain     s [NUM_LANES],
    output logic             o_wr_en,
    output rec_pkg::addr_t   o_wr_addr,
    output i2s_pkg::sample_t o_wr_data
);
    import i2s_pkg::*;
    import rec_pkg::*;

    localparam int SEL_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0] valid_v;
    logic [NUM_LANES-1:0] clear_r;
    logic [NUM_LANES-1:0] pending;
    logic [NUM_LANES-1:0] pick;
    logic                 any_pending;
    sample_t              sample_v [NUM_LANES];
    logic [SEL_W-1:0]     sel;
    addr_t                next_addr_r;
    addr_t                base_addr;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign valid_v[i]  = s[i].valid;
        assign sample_v[i] = s[i].sample;
        assign s[i].clear  = clear_r[i];

        // lane must let go of valid one cycle after its clear
        a_valid_drops: assert property (
            @(posedge i_bclk) disable iff (!i_rst_n)
            s[i].clear |=> !s[i].valid
        );
    end

    // a lane being cleared still shows valid for this cycle
    assign pending     = valid_v & ~clear_r;
    assign any_pending = |pending;
    assign pick        = pending & (~pending + 1'b1);  // lowest lane only

    always_comb begin
        sel = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel = SEL_W'(i);
            end
        end
    end

    // a new run restarts at 0 even if a write goes out this cycle
    assign base_addr = i_new_take_run ? '0 : next_addr_r;

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wr_en     <= 1'b0;
            clear_r     <= '0;
            next_addr_r <= '0;
        end else begin
            o_wr_en     <= any_pending;
            clear_r     <= pick;
            next_addr_r <= any_pending ? base_addr + 1'b1 : base_addr;
        end
    end

    always_ff @(posedge i_bclk) begin
        if (any_pending) begin
            o_wr_addr <= base_addr;
            o_wr_data <= sample_v[sel];
        end
    end

endmodule

//--- hdl/aud_rec_top.sv
module aud_rec_top #(
    parameter int NUM_LANES      = 4,
    parameter int FRAMES_PER_SEC = 48000
) (
    input  logic                 i_bclk,
    input  logic                 i_rst_n,
    input  logic                 i_daclrck,
    input  logic [NUM_LANES-1:0] i_adcdat,
    input  logic                 i_start,
    input  logic                 i_pause,
    input  logic                 i_stop,
    output logic                 o_wr_en,
    output rec_pkg::addr_t       o_wr_addr,
    output i2s_pkg::sample_t     o_wr_data,
    output rec_pkg::second_t     o_second,
    output logic                 o_recording
);

    logic take;
    logic new_take_run;

    lane_sample_if lane_bus [NUM_LANES] ();

    rec_sequencer #(
        .FRAMES_PER_SEC (FRAMES_PER_SEC)
    ) u_seq (
        .i_bclk         (i_bclk),
        .i_rst_n        (i_rst_n),
        .i_daclrck      (i_daclrck),
        .i_start        (i_start),
        .i_pause        (i_pause),
        .i_stop         (i_stop),
        .o_take         (take),
        .o_new_take_run (new_take_run),
        .o_second       (o_second),
        .o_recording    (o_recording)
    );

    // one receiver per adc data line, all on the same take
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_rx
        i2s_rx_lane u_lane (
            .i_bclk   (i_bclk),
            .i_rst_n  (i_rst_n),
            .i_take   (take),
            .i_adcdat (i_adcdat[g]),
            .s        (lane_bus[g])
        );
    end

    sample_writer #(
        .NUM_LANES (NUM_LANES)
    ) u_writer (
        .i_bclk         (i_bclk),
        .i_rst_n        (i_rst_n),
        .i_new_take_run (new_take_run),
        .s              (lane_bus),
        .o_wr_en        (o_wr_en),
        .o_wr_addr      (o_wr_addr),
        .o_wr_data      (o_wr_data)
    );

endmodule

//--- tests/i2s_source.sv
module i2s_source #(
    parameter int NUM_LANES  = 4,
    parameter int FRAME_BITS = 64
) (
    input  logic                 i_bclk,
    output logic                 o_daclrck,
    output logic [NUM_LANES-1:0] o_adcdat
);
    timeunit 1ns;
    timeprecision 100ps;

    import i2s_pkg::*;

    // lrck idles high so the first frame starts with a fall
    initial begin
        o_daclrck = 1'b1;
        o_adcdat  = '0;
    end

    // one frame, left half low then right half high
    // bit 0 is the delay slot, bits 1..16 carry the left sample msb first,
    // every other slot takes its bit from noise
    task automatic send_frame(
        input logic [NUM_LANES-1:0][SAMPLE_W-1:0]   smp,
        input logic [NUM_LANES-1:0][FRAME_BITS-1:0] noise
    );
        for (int b = 0; b < FRAME_BITS; b++) begin
            @(negedge i_bclk);
            o_daclrck = (b >= FRAME_BITS / 2);
            for (int l = 0; l < NUM_LANES; l++) begin
                if (b >= 1 && b <= SAMPLE_W) begin
                    o_adcdat[l] = smp[l][SAMPLE_W-b];
                end else begin
                    o_adcdat[l] = noise[l][b];  // delay bit, tail and right channel
                end
            end
        end
    endtask

endmodule

//--- tests/tb_aud_rec.sv
module tb_aud_rec;
    timeunit 1ns;
    timeprecision 100ps;

    import i2s_pkg::*;
    import rec_pkg::*;

    localparam int NUM_LANES      = 4;
    localparam int FRAMES_PER_SEC = 4;
    localparam int FRAME_BITS     = 64;
    localparam int CLK_PERIOD     = 100;

    localparam int OP_FRAME       = 0;
    localparam int OP_START       = 1;
    localparam int OP_PAUSE       = 2;
    localparam int OP_STOP        = 3;
    localparam int OP_FRAME_PAUSE = 4;  // pause lands mid-frame, after the take
    localparam int OP_FRAME_STOP  = 5;
    localparam int NUM_OPS        = 28;

    typedef struct packed {
        int      frame;
        int      lane;
        sample_t data;
    } sent_t;

    typedef struct packed {
        addr_t   addr;
        sample_t data;
        logic    last;  // last lane of a frame
        second_t sec;
    } wr_t;

    int script [NUM_OPS] = '{
        OP_START, OP_FRAME, OP_FRAME, OP_FRAME, OP_FRAME, OP_FRAME,
        OP_PAUSE, OP_FRAME, OP_FRAME,
        OP_START, OP_FRAME, OP_FRAME, OP_FRAME_PAUSE, OP_FRAME,
        OP_START, OP_FRAME, OP_FRAME,
        OP_STOP, OP_FRAME,
        OP_START, OP_FRAME, OP_FRAME, OP_FRAME_STOP, OP_FRAME,
        OP_START, OP_FRAME, OP_FRAME, OP_FRAME
    };

    int    seed    = 32'hf0ca;
    logic  stopped = 1'b1;  // sequencer idle, next start is a fresh run
    sent_t sent_q [$];
    wr_t   exp_q [$];

    logic                 i_bclk = 1'b0;
    logic                 i_rst_n;
    logic                 i_daclrck;
    logic [NUM_LANES-1:0] i_adcdat;
    logic                 i_start;
    logic                 i_pause;
    logic                 i_stop;
    logic                 o_wr_en;
    addr_t                o_wr_addr;
    sample_t              o_wr_data;
    second_t              o_second;
    logic                 o_recording;

    always #(CLK_PERIOD / 2) i_bclk = ~i_bclk;

    aud_rec_top #(
        .NUM_LANES      (NUM_LANES),
        .FRAMES_PER_SEC (FRAMES_PER_SEC)
    ) uut (
        .i_bclk      (i_bclk),
        .i_rst_n     (i_rst_n),
        .i_daclrck   (i_daclrck),
        .i_adcdat    (i_adcdat),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .o_wr_en     (o_wr_en),
        .o_wr_addr   (o_wr_addr),
        .o_wr_data   (o_wr_data),
        .o_second    (o_second),
        .o_recording (o_recording)
    );

    i2s_source #(
        .NUM_LANES  (NUM_LANES),
        .FRAME_BITS (FRAME_BITS)
    ) u_src (
        .i_bclk    (i_bclk),
        .o_daclrck (i_daclrck),
        .o_adcdat  (i_adcdat)
    );

    task automatic stop_on_error();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %04h, expected %04h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %05h, expected %05h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_second(input second_t got, input second_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    function automatic bit is_frame(input int op);
        return op == OP_FRAME || op == OP_FRAME_PAUSE || op == OP_FRAME_STOP;
    endfunction

    function automatic int count_frames();
        int n = 0;
        foreach (script[i]) begin
            if (is_frame(script[i])) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic sample_t sent_sample(input int frame, input int lane);
        foreach (sent_q[i]) begin
            if (sent_q[i].frame == frame && sent_q[i].lane == lane) begin
                return sent_q[i].data;
            end
        end
        return 'x;
    endfunction

    // expected writes from the record rules, walking the script in order
    function automatic void build_expected();
        int    frame  = 0;
        int    taken  = 0;
        addr_t addr   = '0;
        logic  rec    = 1'b0;
        logic  paused = 1'b0;
        wr_t   w;
        foreach (script[i]) begin
            if (script[i] == OP_START) begin
                if (!rec && !paused) begin  // fresh run from idle
                    addr  = '0;
                    taken = 0;
                end
                rec    = 1'b1;
                paused = 1'b0;
            end else if (script[i] == OP_PAUSE) begin
                paused = rec;
                rec    = 1'b0;
            end else if (script[i] == OP_STOP) begin
                rec    = 1'b0;
                paused = 1'b0;
            end else begin
                if (rec) begin
                    taken++;
                    for (int l = 0; l < NUM_LANES; l++) begin
                        w.addr = addr;
                        w.data = sent_sample(frame, l);
                        w.last = (l == NUM_LANES - 1);
                        w.sec  = second_t'((taken / FRAMES_PER_SEC) % 16);
                        exp_q.push_back(w);
                        addr++;
                    end
                end
                // a control inside a taken frame acts after it
                if (script[i] == OP_FRAME_PAUSE) begin
                    paused = rec;
                    rec    = 1'b0;
                end else if (script[i] == OP_FRAME_STOP) begin
                    rec    = 1'b0;
                    paused = 1'b0;
                end
                frame++;
            end
        end
    endfunction

    task automatic pulse_ctrl(input int op);
        second_t sec_before;
        sec_before = o_second;
        @(negedge i_bclk);
        i_start = (op == OP_START);
        i_pause = (op == OP_PAUSE);
        i_stop  = (op == OP_STOP);
        @(negedge i_bclk);
        i_start = 1'b0;
        i_pause = 1'b0;
        i_stop  = 1'b0;
        if (op == OP_START) begin
            check_flag(o_recording, 1'b1, "recording after start");
            check_second(o_second, stopped ? second_t'(0) : sec_before, "seconds after start");
            stopped = 1'b0;
        end else begin
            check_flag(o_recording, 1'b0, "recording after pause or stop");
            if (op == OP_STOP) begin
                stopped = 1'b1;
            end
        end
    endtask

    task automatic send_one(input int frame, input int mid_op);
        logic [NUM_LANES-1:0][SAMPLE_W-1:0]   smp;
        logic [NUM_LANES-1:0][FRAME_BITS-1:0] noise;
        for (int l = 0; l < NUM_LANES; l++) begin
            smp[l]   = sent_sample(frame, l);
            noise[l] = {$random(seed), $random(seed)};
        end
        fork
            u_src.send_frame(smp, noise);
            begin
                if (mid_op != OP_FRAME) begin
                    repeat (10) @(negedge i_bclk);  // well after the take
                    pulse_ctrl(mid_op);
                end
            end
        join
    endtask

    initial begin : main
        int    frame;
        sent_t s;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_pause = 1'b0;
        i_stop  = 1'b0;
        for (int f = 0; f < count_frames(); f++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                s.frame = f;
                s.lane  = l;
                s.data  = sample_t'($random(seed));
                sent_q.push_back(s);
            end
        end
        build_expected();
        repeat (8) @(negedge i_bclk);
        i_rst_n = 1'b1;
        repeat (4) @(negedge i_bclk);
        frame = 0;
        foreach (script[i]) begin
            if (script[i] == OP_FRAME) begin
                send_one(frame, OP_FRAME);
                frame++;
            end else if (script[i] == OP_FRAME_PAUSE) begin
                send_one(frame, OP_PAUSE);
                frame++;
            end else if (script[i] == OP_FRAME_STOP) begin
                send_one(frame, OP_STOP);
                frame++;
            end else begin
                pulse_ctrl(script[i]);
            end
        end
        while (exp_q.size() != 0) begin
            @(negedge i_bclk);
        end
        repeat (FRAME_BITS) @(negedge i_bclk);  // room for a stray write
        $display("sim passed");
        $finish;
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge i_bclk) begin
        wr_t w;
        if (i_rst_n && o_wr_en) begin
            if (exp_q.size() == 0) begin
                $display("write to address %05h at %0t ns when none was expected",
                         o_wr_addr, $time);
                stop_on_error();
            end else begin
                w = exp_q.pop_front();
                check_addr(o_wr_addr, w.addr, "write address");
                check_sample(o_wr_data, w.data, "write data");
                if (w.last) begin
                    check_second(o_second, w.sec, "seconds after frame");
                end
            end
        end
    end

    initial begin : watchdog
        longint limit_ns;
        limit_ns = longint'(count_frames() + 4) * FRAME_BITS * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog ran out after %0d ns, %0d writes never arrived",
                 limit_ns, exp_q.size());
        stop_on_error();
    end

endmodule

//--- sim.f
hdl/i2s_pkg.sv
hdl/rec_pkg.sv
hdl/lane_sample_if.sv
hdl/rec_sequencer.sv
hdl/i2s_rx_lane.sv
hdl/sample_writer.sv
hdl/aud_rec_top.sv
tests/i2s_source.sv
tests/tb_aud_rec.sv
